/* Bender.yml */
package:
  name: latsc

export_include_dirs:
  - include

sources:
  - hw/latsc_pkg.sv
  - hw/latsc_sync_fifo.sv
  - hw/latsc_fence_gate.sv
  - hw/latsc_delay_slots.sv
  - hw/latsc_top.sv
  - target: test
    files:
      - dv/latsc_tb.sv

/* dv/latsc_tb.sv */
// ------------------------------
// Testbench for the latency scoreboard top level
// Replays dv/latsc_tests.txt and checks every response
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "latsc_consts.svh"

module latsc_tb;

   import latsc_pkg::*;

   localparam int MAX_TESTS  = 64;
   localparam int TIMEOUT    = 2000;
   localparam int MAX_CYCLES = 20000;

   logic                     clk;
   logic                     rst;
   logic                     req_valid_i;
   logic                     req_ready_o;
   logic [`LATSC_OP_W-1:0]   req_op_i;
   logic [`LATSC_ADDR_W-1:0] req_addr_i;
   logic [`LATSC_DATA_W-1:0] req_data_i;
   logic                     full_o;
   logic                     rsp_valid_o;
   logic                     rsp_ready_i;
   logic [`LATSC_TAG_W-1:0]  rsp_tag_o;
   logic [`LATSC_OP_W-1:0]   rsp_op_o;
   logic [`LATSC_ADDR_W-1:0] rsp_addr_o;
   logic [`LATSC_DATA_W-1:0] rsp_data_o;

   // Test table with one entry per file line
   string                    t_name [MAX_TESTS];
   logic [`LATSC_OP_W-1:0]   t_op [MAX_TESTS];
   logic [`LATSC_ADDR_W-1:0] t_addr [MAX_TESTS];
   logic [`LATSC_DATA_W-1:0] t_data [MAX_TESTS];
   int                       t_stall [MAX_TESTS];
   int                       t_fence_before [MAX_TESTS];
   int                       t_err [MAX_TESTS];
   bit                       t_done [MAX_TESTS];
   logic [`LATSC_TAG_W-1:0]  acc_tag [MAX_TESTS];
   int                       acc_cyc [MAX_TESTS];

   int                       n_tests;
   int                       n_rsp_exp;
   int                       rsp_cnt;
   int                       idx;
   int                       cur;
   int                       err_cnt;
   int                       idle_cyc;
   int                       n_pass;
   int                       n_fail;
   int                       cyc = 0;
   logic [`LATSC_TAG_W-1:0]  tag_model;
   logic [15:0]              rnd;
   bit                       released;
   bit                       saw_full;
   bit                       has_bp;
   bit                       timed_out;
   bit                       progress;

   latsc_top UUT (
      .clk(clk), .rst(rst),
      .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i),
      .req_addr_i(req_addr_i), .req_data_i(req_data_i), .full_o(full_o),
      .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_tag_o(rsp_tag_o),
      .rsp_op_o(rsp_op_o), .rsp_addr_o(rsp_addr_o), .rsp_data_o(rsp_data_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Cycle count steps on each rising edge
   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // 16-bit xorshift with shifts 7, 9 and 8
   function automatic logic [15:0] xorshift16(input logic [15:0] s);
      logic [15:0] x;
      x = s;
      x = x ^ (x << 7);
      x = x ^ (x >> 9);
      x = x ^ (x << 8);
      return x;
   endfunction

   // Shortest legal acceptance-to-response time
   function automatic int min_latency(input logic [`LATSC_OP_W-1:0] op);
      case (op)
         3'd0:    return int'(`LATSC_RDLINE_MIN) + 4;
         3'd1:    return int'(`LATSC_WRLINE_MIN) + 4;
         3'd2:    return int'(`LATSC_WRTHRU_MIN) + 4;
         3'd4:    return int'(`LATSC_INTR_MIN) + 4;
         default: return int'(`LATSC_LAT_UNDEF) + 4;
      endcase
   endfunction

   // Unique addresses name the line
   function automatic int find_line(input logic [`LATSC_ADDR_W-1:0] addr);
      int hit;
      hit = -1;
      for (int i = 0; i < n_tests; i++) begin
         if (t_addr[i] == addr) begin
            hit = i;
         end
      end
      return hit;
   endfunction

   task automatic note_error(input int i);
      err_cnt++;
      if (i >= 0) begin
         t_err[i]++;
      end
   endtask

   task automatic check_tag(input int i, input logic [`LATSC_TAG_W-1:0] exp,
                            input logic [`LATSC_TAG_W-1:0] act);
      if (act !== exp) begin
         $display("mismatch %s tag expected %0d actual %0d", t_name[i], exp, act);
         note_error(i);
      end
   endtask

   task automatic check_op(input int i, input latsc_op_e exp, input latsc_op_e act);
      if (act !== exp) begin
         $display("mismatch %s op expected %0d actual %0d", t_name[i], exp, act);
         note_error(i);
      end
   endtask

   task automatic check_addr(input int i, input logic [`LATSC_ADDR_W-1:0] exp,
                             input logic [`LATSC_ADDR_W-1:0] act);
      if (act !== exp) begin
         $display("mismatch %s addr expected %h actual %h", t_name[i], exp, act);
         note_error(i);
      end
   endtask

   task automatic check_data(input int i, input logic [`LATSC_DATA_W-1:0] exp,
                             input logic [`LATSC_DATA_W-1:0] act);
      if (act !== exp) begin
         $display("mismatch %s data expected %h actual %h", t_name[i], exp, act);
         note_error(i);
      end
   endtask

   task automatic check_latency(input int i, input int exp_min, input int act);
      if (act < exp_min) begin
         $display("mismatch %s latency expected >= %0d actual %0d", t_name[i], exp_min, act);
         note_error(i);
      end
   endtask

   // Everything accepted before the last earlier fence must be out already
   task automatic check_fence_order(input int i);
      int f;
      f = t_fence_before[i];
      for (int j = 0; j < f; j++) begin
         if (t_op[j] != 3'd3 && !t_done[j]) begin
            $display("%s came out before %s across %s", t_name[i], t_name[j], t_name[f]);
            note_error(i);
         end
      end
   endtask

   task automatic load_tests();
      int                       fd;
      int                       r;
      int                       stall;
      int                       last_fence;
      string                    line;
      string                    name;
      logic [`LATSC_OP_W-1:0]   op;
      logic [`LATSC_ADDR_W-1:0] addr;
      logic [`LATSC_DATA_W-1:0] data;
      last_fence = -1;
      fd = $fopen("dv/latsc_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open the test file dv/latsc_tests.txt");
         return;
      end
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
         line = "";
         r = $fgets(line, fd);
         // Skip blanks and comment lines
         if (r > 0 && line.len() > 2 && line.getc(0) != "#") begin
            r = $sscanf(line, "%s %h %h %h %d", name, op, addr, data, stall);
            if (r == 5) begin
               t_name[n_tests] = name;
               t_op[n_tests] = op;
               t_addr[n_tests] = addr;
               t_data[n_tests] = data;
               t_stall[n_tests] = stall;
               t_fence_before[n_tests] = last_fence;
               t_err[n_tests] = 0;
               t_done[n_tests] = 1'b0;
               if (op == 3'd3) begin
                  last_fence = n_tests;
               end else begin
                  n_rsp_exp++;
               end
               if (stall == 1) begin
                  has_bp = 1'b1;
               end
               n_tests++;
            end
         end
      end
      $fclose(fd);
   endtask

   // Driven on the falling edge and held until accepted
   task automatic drive_inputs();
      if (idx < n_tests) begin
         cur = idx;
         req_valid_i = 1'b1;
         req_op_i = t_op[idx];
         req_addr_i = t_addr[idx];
         req_data_i = t_data[idx];
      end else begin
         cur = n_tests - 1;
         req_valid_i = 1'b0;
      end
      // Output ready follows the stall mode of the line on offer
      case (t_stall[cur])
         1: rsp_ready_i = released;
         2: begin
            rsp_ready_i = (rnd[1:0] != 2'b00);
            rnd = xorshift16(rnd);
         end
         default: rsp_ready_i = 1'b1;
      endcase
   endtask

   task automatic take_response();
      int i;
      int lat;
      i = find_line(rsp_addr_o);
      if (i < 0) begin
         $display("response with unknown address %h and tag %0d", rsp_addr_o, rsp_tag_o);
         note_error(-1);
      end else if (t_op[i] == 3'd3) begin
         $display("fence %s appeared at the output", t_name[i]);
         note_error(i);
      end else if (t_done[i]) begin
         $display("response for %s delivered twice", t_name[i]);
         note_error(i);
      end else if (i >= idx) begin
         $display("response for %s before it was accepted", t_name[i]);
         note_error(i);
      end else begin
         t_done[i] = 1'b1;
         rsp_cnt++;
         lat = cyc + 1 - acc_cyc[i];
         check_tag(i, acc_tag[i], rsp_tag_o);
         check_op(i, latsc_op_e'(t_op[i]), latsc_op_e'(rsp_op_o));
         check_addr(i, t_addr[i], rsp_addr_o);
         check_data(i, t_data[i], rsp_data_o);
         check_latency(i, min_latency(t_op[i]), lat);
         check_fence_order(i);
         if (t_err[i] == 0) begin
            $display("test %s: ok, latency %0d", t_name[i], lat);
         end else begin
            $display("test %s: error, latency %0d", t_name[i], lat);
         end
      end
   endtask

   // Values seen here hold until the next rising edge
   task automatic observe_outputs();
      progress = 1'b0;
      if (t_stall[cur] == 1 && !released && full_o) begin
         if (req_ready_o !== 1'b0) begin
            $display("req_ready_o still high while full_o is high in %s", t_name[cur]);
            note_error(cur);
         end
         released = 1'b1;
         saw_full = 1'b1;
      end
      if (req_valid_i && req_ready_o) begin
         acc_cyc[idx] = cyc + 1;
         acc_tag[idx] = tag_model;
         tag_model++;
         idx++;
         progress = 1'b1;
      end
      if (rsp_valid_o && rsp_ready_i) begin
         take_response();
         progress = 1'b1;
      end
      if (progress) begin
         idle_cyc = 0;
      end else begin
         idle_cyc++;
      end
      if (idle_cyc > TIMEOUT || cyc > MAX_CYCLES) begin
         timed_out = 1'b1;
      end
   endtask

   initial begin
      rst = 1'b1;
      req_valid_i = 1'b0;
      req_op_i = '0;
      req_addr_i = '0;
      req_data_i = '0;
      rsp_ready_i = 1'b1;
      n_tests = 0;
      n_rsp_exp = 0;
      rsp_cnt = 0;
      idx = 0;
      cur = 0;
      err_cnt = 0;
      idle_cyc = 0;
      tag_model = '0;
      rnd = 16'd60530;
      released = 1'b0;
      saw_full = 1'b0;
      has_bp = 1'b0;
      timed_out = 1'b0;
      load_tests();
      if (n_tests == 0) begin
         $display("no tests loaded");
         note_error(-1);
      end

      repeat (16) @(negedge clk);
      rst = 1'b0;

      // State right after reset
      @(negedge clk);
      #1;
      if (req_ready_o !== 1'b1 || rsp_valid_o !== 1'b0 || full_o !== 1'b0) begin
         $display("reset state wrong, req_ready_o %b rsp_valid_o %b full_o %b",
                  req_ready_o, rsp_valid_o, full_o);
         note_error(-1);
      end else begin
         $display("test reset_state: ok");
      end

      // Offer every line and collect every response
      while ((idx < n_tests || rsp_cnt < n_rsp_exp) && !timed_out) begin
         @(negedge clk);
         drive_inputs();
         #1;
         observe_outputs();
      end

      if (timed_out) begin
         if (idx < n_tests) begin
            $display("request never accepted in %s", t_name[idx]);
            note_error(idx);
         end else begin
            for (int j = 0; j < n_tests; j++) begin
               if (t_op[j] != 3'd3 && !t_done[j]) begin
                  $display("response never arrived in %s", t_name[j]);
                  note_error(j);
               end
            end
         end
      end else begin
         // Nothing more may come out once drained
         req_valid_i = 1'b0;
         rsp_ready_i = 1'b1;
         for (int k = 0; k < 40; k++) begin
            @(negedge clk);
            #1;
            if (rsp_valid_o) begin
               $display("extra response with tag %0d", rsp_tag_o);
               note_error(-1);
            end
         end
      end

      if (has_bp && !saw_full) begin
         $display("full_o never rose while rsp_ready_i was held low");
         note_error(-1);
      end

      n_pass = 0;
      n_fail = 0;
      for (int j = 0; j < n_tests; j++) begin
         if (t_op[j] == 3'd3) begin
            $display("test %s: %s, not forwarded", t_name[j], t_err[j] == 0 ? "ok" : "error");
         end
         if (t_err[j] == 0 && (t_op[j] == 3'd3 || t_done[j])) begin
            n_pass++;
         end else begin
            n_fail++;
         end
      end
      $display("tests %0d, passed %0d, failed %0d, errors %0d", n_tests, n_pass, n_fail,
               err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dv/latsc_tests.txt */
# name op(hex) addr(hex) data(hex) stall; addresses are unique per line
# op 0 rdline 1 wrline 2 wrthru 3 fence 4 intr 5-7 undefined; stall 0 ready 1 held low 2 random
rd_basic     0 1000 a5a50001 0
wr_line      1 1004 a5a50002 0
wr_thru      2 1008 a5a50003 0
intr_short   4 100c a5a50004 0
undef_op7    7 1010 a5a50005 0
fence_a      3 1014 00000000 0
rd_after_a   0 1018 a5a50006 0
bp_rd        0 2000 5a5a0001 1
fence_bp     3 2004 00000000 1
bp_wr_0      1 2008 5a5a0002 1
bp_thru_1    2 200c 5a5a0003 1
bp_rd_2      0 2010 5a5a0004 1
bp_intr_3    4 2014 5a5a0005 1
bp_wr_4      1 2018 5a5a0006 1
bp_undef_5   5 201c 5a5a0007 1
bp_rd_6      0 2020 5a5a0008 1
rnd_rd       0 3000 c3c30001 2
rnd_wr       1 3004 c3c30002 2
rnd_thru     2 3008 c3c30003 2
rnd_intr     4 300c c3c30004 2
fence_rnd    3 3010 00000000 2
rnd_rd_post  0 3014 c3c30005 2
rnd_wr_post  1 3018 c3c30006 2
rnd_undef    6 301c c3c30007 2

/* hw/latsc_delay_slots.sv */
// ----------------------------
// Latency slot array with per-slot countdown
// Requests leave in order of expiry
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "latsc_consts.svh"

module latsc_delay_slots (
   input  wire logic                     clk,
   input  wire logic                     rst,
   // Push side
   input  wire logic                     in_valid_i,
   output logic                          in_ready_o,
   input  wire logic [`LATSC_TAG_W-1:0]  in_tag_i,
   input  wire latsc_pkg::latsc_op_e     in_op_i,
   input  wire logic [`LATSC_ADDR_W-1:0] in_addr_i,
   input  wire logic [`LATSC_DATA_W-1:0] in_data_i,
   // Pop side with a registered output
   output logic                          out_valid_o,
   input  wire logic                     out_ready_i,
   output logic [`LATSC_ENTRY_W-1:0]     out_data_o,
   // All slots free
   output logic                          idle_o
);

   import latsc_pkg::*;

   localparam int SLOT_IW = $clog2(`LATSC_NUM_SLOTS);

   // Slot storage
   logic [`LATSC_ENTRY_W-1:0] slot_entry [`LATSC_NUM_SLOTS];
   logic [7:0]                slot_cnt   [`LATSC_NUM_SLOTS];
   latsc_slot_state_e         slot_state [`LATSC_NUM_SLOTS];

   logic [15:0]        lfsr;
   logic               lfsr_fb;
   logic [7:0]         lat_min;
   logic [7:0]         lat_span;
   logic [15:0]        lat_off;
   logic [7:0]         push_delay;

   logic               push_hit;
   logic [SLOT_IW-1:0] push_idx;
   logic               push_go;
   logic               pop_hit;
   logic [SLOT_IW-1:0] pop_idx;
   logic               pop_go;
   logic [SLOT_IW-1:0] rr_ptr;
   logic               out_done;

   // x^16 + x^14 + x^13 + x^11 + 1
   assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

   // Delay range per opcode
   always_comb begin
      case (in_op_i)
         OP_RDLINE: begin
            lat_min  = `LATSC_RDLINE_MIN;
            lat_span = `LATSC_RDLINE_MAX - `LATSC_RDLINE_MIN + 8'd1;
         end
         OP_WRLINE: begin
            lat_min  = `LATSC_WRLINE_MIN;
            lat_span = `LATSC_WRLINE_MAX - `LATSC_WRLINE_MIN + 8'd1;
         end
         OP_WRTHRU: begin
            lat_min  = `LATSC_WRTHRU_MIN;
            lat_span = `LATSC_WRTHRU_MAX - `LATSC_WRTHRU_MIN + 8'd1;
         end
         OP_INTR: begin
            lat_min  = `LATSC_INTR_MIN;
            lat_span = `LATSC_INTR_MAX - `LATSC_INTR_MIN + 8'd1;
         end
         // A span of one gives undefined codes a fixed delay
         default: begin
            lat_min  = `LATSC_LAT_UNDEF;
            lat_span = 8'd1;
         end
      endcase
   end

   assign lat_off    = lfsr % {8'd0, lat_span};
   assign push_delay = lat_min + lat_off[7:0];

   // Lowest free slot wins
   always_comb begin
      push_hit = 1'b0;
      push_idx = '0;
      for (int i = `LATSC_NUM_SLOTS - 1; i >= 0; i--) begin
         if (slot_state[i] == SLOT_FREE) begin
            push_hit = 1'b1;
            push_idx = SLOT_IW'(i);
         end
      end
   end

   // Round robin picks the first done slot after the last popped one
   always_comb begin
      logic [SLOT_IW-1:0] cand;
      pop_hit = 1'b0;
      pop_idx = '0;
      for (int k = `LATSC_NUM_SLOTS; k >= 1; k--) begin
         cand = rr_ptr + SLOT_IW'(k);
         if (slot_state[cand] == SLOT_DONE) begin
            pop_hit = 1'b1;
            pop_idx = cand;
         end
      end
   end

   assign in_ready_o = push_hit;
   assign push_go    = in_valid_i && push_hit;
   assign out_done   = out_valid_o && out_ready_i;
   // Output register free or draining this cycle
   assign pop_go     = pop_hit && (!out_valid_o || out_ready_i);

   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr        <= `LATSC_LFSR_SEED;
         rr_ptr      <= SLOT_IW'(`LATSC_NUM_SLOTS - 1);
         out_valid_o <= 1'b0;
         for (int i = 0; i < `LATSC_NUM_SLOTS; i++) begin
            slot_state[i] <= SLOT_FREE;
            slot_cnt[i]   <= '0;
         end
      end else begin
         lfsr <= {lfsr[14:0], lfsr_fb};
         for (int i = 0; i < `LATSC_NUM_SLOTS; i++) begin
            case (slot_state[i])
               SLOT_FREE: begin
                  if (push_go && (push_idx == SLOT_IW'(i))) begin
                     slot_cnt[i]   <= push_delay;
                     slot_state[i] <= SLOT_COUNT;
                  end
               end
               // Zero seen one cycle after the last decrement
               SLOT_COUNT: begin
                  if (slot_cnt[i] == 8'd0) begin
                     slot_state[i] <= SLOT_DONE;
                  end else begin
                     slot_cnt[i] <= slot_cnt[i] - 8'd1;
                  end
               end
               SLOT_DONE: begin
                  if (pop_go && (pop_idx == SLOT_IW'(i))) begin
                     slot_state[i] <= SLOT_POP;
                  end
               end
               // Only the slot held in the output register sits here
               SLOT_POP: begin
                  if (out_done) begin
                     slot_state[i] <= SLOT_FREE;
                  end
               end
               default: slot_state[i] <= SLOT_FREE;
            endcase
         end
         if (pop_go) begin
            out_valid_o <= 1'b1;
            rr_ptr      <= pop_idx;
         end else if (out_done) begin
            out_valid_o <= 1'b0;
         end
      end
   end

   // Payload path
   always_ff @(posedge clk) begin
      if (push_go) begin
         slot_entry[push_idx] <= {in_tag_i, in_op_i, in_addr_i, in_data_i};
      end
      if (pop_go) begin
         out_data_o <= slot_entry[pop_idx];
      end
   end

   always_comb begin
      idle_o = 1'b1;
      for (int i = 0; i < `LATSC_NUM_SLOTS; i++) begin
         if (slot_state[i] != SLOT_FREE) begin
            idle_o = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/latsc_fence_gate.sv */
// ----------------------------
// Tags requests and filters write fences
// Sits between the input FIFO and the slot array
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "latsc_consts.svh"

module latsc_fence_gate (
   input  wire logic                      clk,
   input  wire logic                      rst,
   // External request side
   input  wire logic                      req_valid_i,
   input  wire logic [`LATSC_OP_W-1:0]    req_op_i,
   input  wire logic [`LATSC_ADDR_W-1:0]  req_addr_i,
   input  wire logic [`LATSC_DATA_W-1:0]  req_data_i,
   input  wire logic                      in_almfull_i,
   output logic                           in_ready_o,
   output logic                           in_wr_valid_o,
   output logic [`LATSC_ENTRY_W-1:0]      in_tagged_o,
   // Input FIFO head
   input  wire logic                      head_valid_i,
   input  wire logic [`LATSC_ENTRY_W-1:0] head_data_i,
   output logic                           head_ready_o,
   // Toward the slot array
   output logic                           slot_valid_o,
   output logic [`LATSC_TAG_W-1:0]        slot_tag_o,
   output latsc_pkg::latsc_op_e           slot_op_o,
   output logic [`LATSC_ADDR_W-1:0]       slot_addr_o,
   output logic [`LATSC_DATA_W-1:0]       slot_data_o,
   input  wire logic                      slot_ready_i,
   // Drain status for fences
   input  wire logic                      slots_idle_i,
   input  wire logic                      out_fifo_empty_i,
   input  wire logic                      out_push_i
);

   import latsc_pkg::*;

   logic [`LATSC_TAG_W-1:0] tag_q;
   logic                    head_is_fence;
   logic                    drained;

   // Accept while the input FIFO has headroom
   assign in_ready_o    = ~in_almfull_i;
   assign in_wr_valid_o = req_valid_i && in_ready_o;
   assign in_tagged_o   = {tag_q, req_op_i, req_addr_i, req_data_i};

   // Tag counter counts fences too and wraps freely
   always_ff @(posedge clk) begin
      if (rst) begin
         tag_q <= '0;
      end else if (in_wr_valid_o) begin
         tag_q <= tag_q + 1'b1;
      end
   end

   // Split head into fields
   assign {slot_tag_o, slot_addr_o, slot_data_o} = {
      head_data_i[`LATSC_ENTRY_W-1 -: `LATSC_TAG_W],
      head_data_i[`LATSC_ADDR_W+`LATSC_DATA_W-1 -: `LATSC_ADDR_W],
      head_data_i[`LATSC_DATA_W-1:0]};
   assign slot_op_o = latsc_op_e'(head_data_i[`LATSC_ADDR_W+`LATSC_DATA_W +: `LATSC_OP_W]);

   assign head_is_fence = head_valid_i && (slot_op_o == OP_WRFENCE);
   // Nothing left downstream and nothing moving into the output FIFO
   assign drained = slots_idle_i && out_fifo_empty_i && !out_push_i;

   // Fences never go to the slots
   assign slot_valid_o = head_valid_i && !head_is_fence;
   assign head_ready_o = head_is_fence ? drained : slot_ready_i;

endmodule

`default_nettype wire

/* hw/latsc_pkg.sv */
// ----------------------------
// Shared types for the latency scoreboard
// Import inside module bodies
// ----------------------------
`default_nettype none

`include "latsc_consts.svh"

package latsc_pkg;

   // Request channel opcodes
   // Codes 5 to 7 are undefined and get the fixed latency
   typedef enum logic [`LATSC_OP_W-1:0] {
      OP_RDLINE  = 3'd0,
      OP_WRLINE  = 3'd1,
      OP_WRTHRU  = 3'd2,
      OP_WRFENCE = 3'd3,
      OP_INTR    = 3'd4
   } latsc_op_e;

   // Each slot cycles through free -> count -> done -> pop -> free
   typedef enum logic [1:0] {
      SLOT_FREE  = 2'd0,
      SLOT_COUNT = 2'd1,
      SLOT_DONE  = 2'd2,
      SLOT_POP   = 2'd3
   } latsc_slot_state_e;

endpackage

`default_nettype wire

/* hw/latsc_sync_fifo.sv */
// ----------------------------
// Synchronous FIFO with valid/ready on both sides
// Used for the input and output stages
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "latsc_consts.svh"

module latsc_sync_fifo #(
   parameter int WIDTH      = `LATSC_ENTRY_W,
   parameter int DEPTH_LOG2 = `LATSC_FIFO_DEPTH_LOG2
) (
   input  wire logic             clk,
   input  wire logic             rst,
   // Write side
   input  wire logic             wr_valid_i,
   output logic                  wr_ready_o,
   input  wire logic [WIDTH-1:0] wr_data_i,
   // Read side
   output logic                  rd_valid_o,
   input  wire logic             rd_ready_i,
   output logic [WIDTH-1:0]      rd_data_o,
   // Status
   output logic                  almfull_o,
   output logic                  empty_o
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   // Storage array
   logic [WIDTH-1:0]      mem [DEPTH];

   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   // One extra bit so a full FIFO is distinct from empty
   logic [DEPTH_LOG2:0]   count;
   logic [DEPTH_LOG2:0]   free_cnt;
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = wr_valid_i && wr_ready_o;
   assign do_rd = rd_valid_o && rd_ready_i;

   // Status from registered count only
   assign free_cnt   = (DEPTH_LOG2+1)'(DEPTH) - count;
   assign wr_ready_o = (count != (DEPTH_LOG2+1)'(DEPTH));
   assign rd_valid_o = (count != '0);
   assign empty_o    = (count == '0);
   assign almfull_o  = (free_cnt < (DEPTH_LOG2+1)'(`LATSC_FIFO_ALMFULL));

   // Head is read straight from the array
   assign rd_data_o = mem[rd_ptr];

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous read and write leaves count alone
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Array write
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

endmodule

`default_nettype wire

/* hw/latsc_top.sv */
// ----------------------------
// Latency scoreboard top level
// Input FIFO, fence gate, slots, output FIFO
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "latsc_consts.svh"

module latsc_top (
   input  wire logic                     clk,
   input  wire logic                     rst,
   // Request channel
   input  wire logic                     req_valid_i,
   output logic                          req_ready_o,
   input  wire logic [`LATSC_OP_W-1:0]   req_op_i,
   input  wire logic [`LATSC_ADDR_W-1:0] req_addr_i,
   input  wire logic [`LATSC_DATA_W-1:0] req_data_i,
   output logic                          full_o,
   // Response channel
   output logic                          rsp_valid_o,
   input  wire logic                     rsp_ready_i,
   output logic [`LATSC_TAG_W-1:0]       rsp_tag_o,
   output logic [`LATSC_OP_W-1:0]        rsp_op_o,
   output logic [`LATSC_ADDR_W-1:0]      rsp_addr_o,
   output logic [`LATSC_DATA_W-1:0]      rsp_data_o
);

   import latsc_pkg::*;

   // Input stage
   logic                      in_almfull;
   logic                      in_wr_valid;
   logic [`LATSC_ENTRY_W-1:0] in_tagged;
   logic                      head_valid;
   logic                      head_ready;
   logic [`LATSC_ENTRY_W-1:0] head_data;
   // Gate to slots
   logic                      slot_valid;
   logic                      slot_ready;
   logic [`LATSC_TAG_W-1:0]   slot_tag;
   latsc_op_e                 slot_op;
   logic [`LATSC_ADDR_W-1:0]  slot_addr;
   logic [`LATSC_DATA_W-1:0]  slot_data;
   logic                      slots_idle;
   // Slots to output stage
   logic                      out_valid;
   logic                      out_ready;
   logic [`LATSC_ENTRY_W-1:0] out_data;
   logic                      out_almfull;
   logic                      out_empty;
   logic                      out_push;
   logic [`LATSC_ENTRY_W-1:0] rsp_entry;

   assign full_o    = in_almfull;
   assign out_ready = ~out_almfull;
   assign out_push  = out_valid && out_ready;

   latsc_sync_fifo #(.WIDTH(`LATSC_ENTRY_W), .DEPTH_LOG2(`LATSC_FIFO_DEPTH_LOG2)) u_in_fifo (
      .clk(clk), .rst(rst),
      .wr_valid_i(in_wr_valid), .wr_ready_o(), .wr_data_i(in_tagged),
      .rd_valid_o(head_valid), .rd_ready_i(head_ready), .rd_data_o(head_data),
      .almfull_o(in_almfull), .empty_o()
   );

   latsc_fence_gate u_fence_gate (
      .clk(clk), .rst(rst),
      .req_valid_i(req_valid_i), .req_op_i(req_op_i),
      .req_addr_i(req_addr_i), .req_data_i(req_data_i),
      .in_almfull_i(in_almfull), .in_ready_o(req_ready_o),
      .in_wr_valid_o(in_wr_valid), .in_tagged_o(in_tagged),
      .head_valid_i(head_valid), .head_data_i(head_data), .head_ready_o(head_ready),
      .slot_valid_o(slot_valid), .slot_tag_o(slot_tag), .slot_op_o(slot_op),
      .slot_addr_o(slot_addr), .slot_data_o(slot_data), .slot_ready_i(slot_ready),
      .slots_idle_i(slots_idle), .out_fifo_empty_i(out_empty), .out_push_i(out_push)
   );

   latsc_delay_slots u_delay_slots (
      .clk(clk), .rst(rst),
      .in_valid_i(slot_valid), .in_ready_o(slot_ready), .in_tag_i(slot_tag),
      .in_op_i(slot_op), .in_addr_i(slot_addr), .in_data_i(slot_data),
      .out_valid_o(out_valid), .out_ready_i(out_ready), .out_data_o(out_data),
      .idle_o(slots_idle)
   );

   // Written only on the slot array handshake
   latsc_sync_fifo #(.WIDTH(`LATSC_ENTRY_W), .DEPTH_LOG2(`LATSC_FIFO_DEPTH_LOG2)) u_out_fifo (
      .clk(clk), .rst(rst),
      .wr_valid_i(out_push), .wr_ready_o(), .wr_data_i(out_data),
      .rd_valid_o(rsp_valid_o), .rd_ready_i(rsp_ready_i), .rd_data_o(rsp_entry),
      .almfull_o(out_almfull), .empty_o(out_empty)
   );

   // Response fields keep the tagged entry packing
   assign {rsp_tag_o, rsp_op_o, rsp_addr_o, rsp_data_o} = rsp_entry;

endmodule

`default_nettype wire

/* include/latsc_consts.svh */
// ----------------------------
// Widths, sizes and delay bounds for the latency scoreboard
// Include wherever a macro below is needed
// ----------------------------
`ifndef LATSC_CONSTS_SVH
`define LATSC_CONSTS_SVH

// Request fields
`define LATSC_ADDR_W 16
`define LATSC_DATA_W 32
`define LATSC_TAG_W 16
`define LATSC_OP_W 3
// Tag + opcode + address + data
`define LATSC_ENTRY_W (`LATSC_TAG_W + `LATSC_OP_W + `LATSC_ADDR_W + `LATSC_DATA_W)

// Latency array and FIFO sizing
`define LATSC_NUM_SLOTS 8
`define LATSC_FIFO_DEPTH_LOG2 3
`define LATSC_FIFO_ALMFULL 2
`define LATSC_LFSR_SEED 16'hACE1

// Inclusive delay bounds in cycles
`define LATSC_RDLINE_MIN 8'd4
`define LATSC_RDLINE_MAX 8'd20
`define LATSC_WRLINE_MIN 8'd6
`define LATSC_WRLINE_MAX 8'd24
`define LATSC_WRTHRU_MIN 8'd2
`define LATSC_WRTHRU_MAX 8'd10
`define LATSC_INTR_MIN 8'd1
`define LATSC_INTR_MAX 8'd4
`define LATSC_LAT_UNDEF 8'd30

`endif

/* verilog.f */
+incdir+include
hw/latsc_pkg.sv
hw/latsc_sync_fifo.sv
hw/latsc_fence_gate.sv
hw/latsc_delay_slots.sv
hw/latsc_top.sv
dv/latsc_tb.sv
